// File: serdes_pkg.sv
`default_nettype none

package serdes_pkg;

  // frame geometry
  localparam int N_SAMPLES = 8;
  localparam int BIT_WIDTH = 16;
  localparam int IDX_WIDTH = $clog2(N_SAMPLES);

  // one data word on the input and output streams
  typedef logic [BIT_WIDTH-1:0] sample_t;

  // element 0 holds the first sample received
  typedef sample_t [N_SAMPLES-1:0] frame_t;

  // position of a sample inside a frame
  typedef logic [IDX_WIDTH-1:0] idx_t;

  // mirrors the index bits, so with 3 bits 3'b001 becomes 3'b100
  function automatic idx_t bit_reverse(input idx_t idx);
    idx_t rev;
    rev = '0;
    for (int b = 0; b < IDX_WIDTH; b++) begin
      rev[b] = idx[IDX_WIDTH-1-b];
    end
    return rev;
  endfunction

endpackage

`default_nettype wire

// File: serdes_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_deserializer
  import serdes_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    in_val,
  output logic    in_rdy,
  input  sample_t in_msg,

  output logic    des_val,
  input  logic    des_rdy,
  output frame_t  des_frame
);

  typedef enum logic {
    FILL = 1'b0,
    FULL = 1'b1
  } state_t;

  state_t state;
  state_t state_next;
  idx_t   count;                      // slot that the next accepted word goes to
  idx_t   count_next;
  logic   in_xfer;
  logic   [N_SAMPLES-1:0] wr_en;      // one-hot enable into the sample registers

  assign in_xfer = in_val && in_rdy;

  // handshake outputs come straight from the state
  always_comb begin
    case (state)
      FILL: begin
        in_rdy  = 1'b1;
        des_val = 1'b0;
      end
      FULL: begin
        in_rdy  = 1'b0;
        des_val = 1'b1;
      end
      default: begin
        in_rdy  = 1'b1;
        des_val = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      FILL: begin
        if (in_xfer) begin
          if (count == idx_t'(N_SAMPLES - 1)) begin
            state_next = FULL;      // the last slot is written and the frame is complete
            count_next = '0;
          end else begin
            count_next = count + idx_t'(1);
          end
        end
      end
      FULL: begin
        if (des_rdy) begin
          state_next = FILL;
        end
      end
      default: begin
        state_next = FILL;
        count_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FILL;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

  // the decoder only fires on an accepted word
  assign wr_en = in_xfer ? (N_SAMPLES'(1) << count) : '0;

  for (genvar i = 0; i < N_SAMPLES; i++) begin : g_sample_reg
    always_ff @(posedge clk) begin
      if (wr_en[i]) begin
        des_frame[i] <= in_msg;
      end
    end
  end

  // once the last word is in, the frame is offered and the input closes
  a_offer_after_last: assert property (@(posedge clk) disable iff (reset)
    (in_xfer && count == idx_t'(N_SAMPLES - 1)) |=> (des_val && !in_rdy))
    else $error("deserializer did not offer the frame after its last word");

  a_count_step: assert property (@(posedge clk) disable iff (reset)
    in_xfer |=> (count == idx_t'($past(count) + 1)))
    else $error("fill counter did not advance on an accepted word: %0d", count);

endmodule

`default_nettype wire

// File: serdes_bitrev_stage.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_bitrev_stage
  import serdes_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  logic   des_val,
  output logic   des_rdy,
  input  frame_t des_frame,

  output logic   rev_val,
  input  logic   rev_rdy,
  output frame_t rev_frame
);

  logic   full;
  logic   load;
  logic   unload;
  frame_t permuted;

  assign des_rdy = !full;             // single entry, so only take a frame when empty
  assign rev_val = full;
  assign load    = des_val && des_rdy;
  assign unload  = rev_val && rev_rdy;

  // position j of the output takes input sample bit_reverse(j)
  always_comb begin
    for (int j = 0; j < N_SAMPLES; j++) begin
      permuted[j] = des_frame[bit_reverse(idx_t'(j))];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (unload) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rev_frame <= permuted;
    end
  end

  // the serializer may sit on a frame for a long time under back-pressure
  a_frame_stable: assert property (@(posedge clk) disable iff (reset)
    (rev_val && !rev_rdy) |=> $stable(rev_frame))
    else $error("reordered frame changed while waiting for the serializer");

endmodule

`default_nettype wire

// File: serdes_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_serializer
  import serdes_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    rev_val,
  output logic    rev_rdy,
  input  frame_t  rev_frame,

  output logic    out_val,
  input  logic    out_rdy,
  output sample_t out_msg
);

  logic   busy;                       // a frame is being sent out
  logic   busy_next;
  idx_t   idx;
  idx_t   idx_next;
  frame_t frame_q;
  logic   load;
  logic   out_xfer;
  logic   last;

  assign rev_rdy  = !busy;
  assign out_val  = busy;
  assign load     = rev_val && rev_rdy;
  assign out_xfer = out_val && out_rdy;
  assign last     = (idx == idx_t'(N_SAMPLES - 1));

  always_comb begin
    busy_next = busy;
    idx_next  = idx;
    if (!busy) begin
      if (load) begin
        busy_next = 1'b1;
        idx_next  = '0;
      end
    end else if (out_xfer) begin
      if (last) begin
        busy_next = 1'b0;           // the frame is done and the next one can load
        idx_next  = '0;
      end else begin
        idx_next = idx + idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      idx  <= '0;
    end else begin
      busy <= busy_next;
      idx  <= idx_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= rev_frame;
    end
  end

  // the sample select walks the held frame in index order
  always_comb begin
    out_msg = frame_q[0];
    for (int k = 0; k < N_SAMPLES; k++) begin
      if (idx == idx_t'(k)) begin
        out_msg = frame_q[k];
      end
    end
  end

  a_msg_stable: assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_msg)))
    else $error("output word changed during a stall");

endmodule

`default_nettype wire

// File: serdes_top.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_top
  import serdes_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  logic    in_val,
  output logic    in_rdy,
  input  sample_t in_msg,

  output logic    out_val,
  input  logic    out_rdy,
  output sample_t out_msg
);

  // deserializer to reorder buffer
  logic   des_val;
  logic   des_rdy;
  frame_t des_frame;

  // reorder buffer to serializer
  logic   rev_val;
  logic   rev_rdy;
  frame_t rev_frame;

  serdes_deserializer serdes_deserializer_inst (
    .clk       (clk),
    .reset     (reset),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .in_msg    (in_msg),
    .des_val   (des_val),
    .des_rdy   (des_rdy),
    .des_frame (des_frame)
  );

  serdes_bitrev_stage serdes_bitrev_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .des_val   (des_val),
    .des_rdy   (des_rdy),
    .des_frame (des_frame),
    .rev_val   (rev_val),
    .rev_rdy   (rev_rdy),
    .rev_frame (rev_frame)
  );

  serdes_serializer serdes_serializer_inst (
    .clk       (clk),
    .reset     (reset),
    .rev_val   (rev_val),
    .rev_rdy   (rev_rdy),
    .rev_frame (rev_frame),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .out_msg   (out_msg)
  );

endmodule

`default_nettype wire

// File: tb_serdes.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serdes
  import serdes_pkg::*;
();

  localparam int WAIT_LIMIT = 400;              // cycles before any wait gives up
  localparam logic [31:0] LFSR_SEED = 32'h21bd_2c92;

  logic        clk = 1'b0;
  logic        reset;
  logic        in_val;
  logic        in_rdy;
  sample_t     in_msg;
  logic        out_val;
  logic        out_rdy = 1'b0;
  sample_t     out_msg;

  logic        stall_mode;                      // when high the sink drops out_rdy at random
  logic [31:0] data_lfsr;
  logic [31:0] sink_lfsr = LFSR_SEED;

  // the reference model is owned by the monitor
  sample_t     expected[$];
  sample_t     group[$];
  sample_t     seen[$];
  int          words_in = 0;
  int          words_out = 0;
  int          stall_run = 0;
  int          stall_cycles = 0;
  int          mon_errors = 0;

  string       test_name = "reset";
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_start_errors;

  serdes_top serdes_top_inst (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  always #20 clk = ~clk;

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // index with its bits read from the other end
  function automatic int mirror_index(input int j);
    int r;
    r = 0;
    for (int b = 0; b < IDX_WIDTH; b++) begin
      r = (r << 1) | ((j >> b) & 1);
    end
    return r;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      val = {val[30:0], data_lfsr[0]};
    end
  endtask

  always @(posedge clk) begin
    if (stall_mode) begin
      sink_lfsr = lfsr_next(sink_lfsr);
      out_rdy <= sink_lfsr[0];
    end else begin
      out_rdy <= 1'b1;
    end
  end

  // handshakes are sampled mid-cycle, where every signal has settled
  always @(negedge clk) begin
    sample_t exp_word;
    if (!reset) begin
      if (in_val && !in_rdy) begin
        stall_run++;
        if (stall_run > 1) begin
          stall_cycles++;                       // one low cycle is the normal frame hand-off
        end
      end else begin
        stall_run = 0;
      end
      if (in_val && in_rdy) begin
        group.push_back(in_msg);
        words_in++;
        if (group.size() == N_SAMPLES) begin
          for (int j = 0; j < N_SAMPLES; j++) begin
            expected.push_back(group[mirror_index(j)]);
          end
          group.delete();
        end
      end
      if (out_val && out_rdy) begin
        words_out++;
        seen.push_back(out_msg);
        if (expected.size() == 0) begin
          $display("test %s: output word %h came out with nothing expected", test_name, out_msg);
          mon_errors++;
        end else begin
          exp_word = expected.pop_front();
          if (out_msg !== exp_word) begin
            $display("** Error [%s] expected %h actual %h", test_name, exp_word, out_msg);
            mon_errors++;
          end
        end
      end
    end
  end

  task automatic expect_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error [%s] %s expected %b actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic expect_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("** Error [%s] %s expected %0d actual %0d", test_name, what, exp, act);
      errors++;
    end
  endtask

  // call right after a rising edge and it returns on the edge that takes the word
  task automatic send_word(input sample_t w);
    int waited;
    waited = 0;
    in_val <= 1'b1;
    in_msg <= w;
    @(negedge clk);
    while (!in_rdy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_rdy) begin
      $display("test %s: in_rdy stayed low for %0d cycles and the input stalled",
               test_name, waited);
      errors++;
    end
    @(posedge clk);
  endtask

  task automatic send_frames(input int frames, input logic gaps);
    logic [31:0] v;
    logic [31:0] g;
    @(posedge clk);
    for (int i = 0; i < frames * N_SAMPLES; i++) begin
      if (gaps) begin
        draw_bits(1, g);
        if (g[0] == 1'b0) begin
          in_val <= 1'b0;                       // an idle cycle must not advance the frame
          @(posedge clk);
        end
      end
      draw_bits(BIT_WIDTH, v);
      send_word(v[BIT_WIDTH-1:0]);
    end
    in_val <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("test %s: %0d expected words never came out", test_name, expected.size());
      errors++;
    end
    repeat (2) @(negedge clk);
    expect_bit("out_val after drain", 1'b0, out_val);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errors = errors + mon_errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors + mon_errors == test_start_errors) begin
      $display("test %-22s ok", test_name);
    end else begin
      $display("test %-22s FAILED with %0d errors", test_name,
               errors + mon_errors - test_start_errors);
      tests_failed++;
    end
  endtask

  task automatic reset_state();
    begin_test("reset_state");
    @(negedge clk);
    expect_bit("out_val", 1'b0, out_val);
    expect_bit("in_rdy", 1'b1, in_rdy);
    repeat (10) begin
      @(negedge clk);
      expect_bit("out_val while idle", 1'b0, out_val);
    end
    end_test();
  endtask

  task automatic single_frame();
    int order [N_SAMPLES];
    int base;
    order = '{0, 4, 2, 6, 1, 5, 3, 7};
    begin_test("single_frame");
    base = seen.size();
    @(posedge clk);
    for (int i = 0; i < N_SAMPLES; i++) begin
      send_word(sample_t'(i));
    end
    in_val <= 1'b0;
    wait_drain();
    expect_count("output words", N_SAMPLES, seen.size() - base);
    if (seen.size() - base == N_SAMPLES) begin
      for (int k = 0; k < N_SAMPLES; k++) begin
        if (seen[base + k] !== sample_t'(order[k])) begin
          $display("** Error [%s] expected %h actual %h", test_name,
                   sample_t'(order[k]), seen[base + k]);
          errors++;
        end
      end
    end
    end_test();
  endtask

  task automatic back_to_back();
    int out_start;
    begin_test("back_to_back");
    out_start = words_out;
    stall_mode <= 1'b0;
    send_frames(4, 1'b0);
    wait_drain();
    expect_count("output words", 4 * N_SAMPLES, words_out - out_start);
    end_test();
  endtask

  task automatic output_stall();
    int out_start;
    int stall_start;
    begin_test("output_stall");
    out_start   = words_out;
    stall_start = stall_cycles;
    stall_mode <= 1'b1;
    send_frames(6, 1'b0);
    wait_drain();
    stall_mode <= 1'b0;
    expect_count("output words", 6 * N_SAMPLES, words_out - out_start);
    if (stall_cycles == stall_start) begin
      $display("test %s: in_rdy never held off the input while the output stalled",
               test_name);
      errors++;
    end
    end_test();
  endtask

  task automatic input_gaps();
    int out_start;
    begin_test("input_gaps");
    out_start = words_out;
    stall_mode <= 1'b0;
    send_frames(3, 1'b1);
    wait_drain();
    expect_count("output words", 3 * N_SAMPLES, words_out - out_start);
    end_test();
  endtask

  task automatic partial_then_complete();
    int out_start;
    begin_test("partial_then_complete");
    out_start = words_out;
    @(posedge clk);
    for (int i = 0; i < 5; i++) begin
      send_word(sample_t'(16'h0100 + i));
    end
    in_val <= 1'b0;
    repeat (20) begin
      @(negedge clk);
      expect_bit("out_val with a partial frame", 1'b0, out_val);
    end
    @(posedge clk);
    for (int i = 5; i < N_SAMPLES; i++) begin
      send_word(sample_t'(16'h0100 + i));
    end
    in_val <= 1'b0;
    wait_drain();
    expect_count("output words", N_SAMPLES, words_out - out_start);
    end_test();
  endtask

  initial begin
    reset        = 1'b1;
    in_val       = 1'b0;
    in_msg       = '0;
    stall_mode   = 1'b0;
    data_lfsr    = LFSR_SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    reset_state();
    single_frame();
    back_to_back();
    output_stall();
    input_gaps();
    partial_then_complete();

    $display("tests run %0d, failed %0d, errors %0d, words in %0d, words out %0d",
             tests_run, tests_failed, errors + mon_errors, words_in, words_out);
    if (errors + mon_errors == 0 && tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
serdes_pkg.sv
serdes_deserializer.sv
serdes_bitrev_stage.sv
serdes_serializer.sv
serdes_top.sv
tb_serdes.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_serdes \
  -f vlog.f -o sim_serdes &&
  ./obj_dir/sim_serdes > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log && echo "run passed" || { echo "run failed"; exit 1; }
